/* dmc_phy_pkg.sv */
package dmc_phy_pkg;

  // dram side of the interface.
  localparam int dq_width_lp   = 16;
  localparam int lane_count_lp = 2;
  localparam int lane_bits_lp  = dq_width_lp / lane_count_lp;  // dq bits per byte lane.

  // one dfi word carries the two beats of a 1x cycle.
  localparam int dfi_data_width_lp = 2 * dq_width_lp;

  localparam int fifo_depth_lp = 4;  // read capture entries per dq bit.
  localparam int ptr_width_lp  = $clog2(fifo_depth_lp);

  // read enable delay line with half-cycle steps of the 2x clock.
  localparam int cal_taps_lp  = 8;
  localparam int cal_width_lp = $clog2(cal_taps_lp);

  localparam int addr_width_lp = 16;
  localparam int bank_width_lp = 3;

endpackage

/* dmc_lane_if.sv */
`timescale 1ns/1ns

interface dmc_lane_if;
  import dmc_phy_pkg::*;

  logic                      wr_en;    // write enable on the 90 degree edge.
  logic [2*lane_bits_lp-1:0] wr_data;  // even byte low, odd byte high.
  logic [1:0]                wr_mask;
  logic                      rp_inc;
  logic [2*lane_bits_lp-1:0] rd_data;  // even byte low, odd byte high.

  modport ctrl (
    output wr_en,
    output wr_data,
    output wr_mask,
    output rp_inc
  );

  modport lane (
    input  wr_en,
    input  wr_data,
    input  wr_mask,
    input  rp_inc,
    output rd_data
  );

  modport gather (
    input  rd_data
  );

endinterface

/* dmc_phy_tx_slice.sv */
`timescale 1ns/1ns

module dmc_phy_tx_slice (
  input  logic       clk_2x_p,
  input  logic       reset_i,
  input  logic       wr_en_i,
  input  logic [1:0] beats_i,
  output logic       pin_o,
  output logic       oe_n_o
);

  logic odd;

  always_ff @(negedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      odd    <= 1'b0;
      oe_n_o <= 1'b1;
    end else if (wr_en_i) begin
      odd    <= ~odd;
      oe_n_o <= 1'b0;
    end else begin
      odd    <= 1'b0;  // every burst starts on the even beat.
      oe_n_o <= 1'b1;
    end
  end

  always_ff @(negedge clk_2x_p) begin
    if (wr_en_i) begin
      pin_o <= odd ? beats_i[1] : beats_i[0];
    end
  end

  // beats go out in pairs, so the enable only drops after an odd beat.
  a_whole_word: assert property (@(negedge clk_2x_p) disable iff (reset_i)
    (!wr_en_i && !oe_n_o) |-> !odd);

endmodule

/* dmc_phy_rx_slice.sv */
`timescale 1ns/1ns

module dmc_phy_rx_slice (
  input  logic                                 clk_2x_p,
  input  logic                                 dq_i,
  input  logic                                 dqs_p_i,
  input  logic                                 dqs_n_i,
  input  logic [dmc_phy_pkg::ptr_width_lp-1:0] wr_ptr_i,
  input  logic [dmc_phy_pkg::ptr_width_lp-1:0] rd_ptr_i,
  output logic                                 rd_even_o,
  output logic                                 rd_odd_o
);
  import dmc_phy_pkg::*;

  logic even_q [fifo_depth_lp];
  logic odd_q  [fifo_depth_lp];

  // the even beat lands on the dqs rising edge.
  always_ff @(posedge dqs_p_i) begin
    even_q[wr_ptr_i] <= dq_i;
  end

  // the odd beat lands on the dqs falling edge, seen here as dqs_n rising.
  // the write pointer steps on this same edge, so the old value is used.
  always_ff @(posedge dqs_n_i) begin
    odd_q[wr_ptr_i] <= dq_i;
  end

  // retimed on every rising edge of the core clock.
  // the gatherer takes it on the sampling edge, half a 1x cycle after the pick.
  always_ff @(posedge clk_2x_p) begin
    rd_even_o <= even_q[rd_ptr_i];
    rd_odd_o  <= odd_q[rd_ptr_i];
  end

endmodule

/* dmc_phy_byte_lane.sv */
`timescale 1ns/1ns

module dmc_phy_byte_lane (
  input  logic                                 clk_2x_p,
  input  logic                                 reset_i,
  input  logic                                 ck_phase_i,
  dmc_lane_if.lane                             bus,
  input  logic [dmc_phy_pkg::lane_bits_lp-1:0] dq_i,
  input  logic                                 dqs_p_i,
  input  logic                                 dqs_n_i,
  output logic [dmc_phy_pkg::lane_bits_lp-1:0] dq_o,
  output logic [dmc_phy_pkg::lane_bits_lp-1:0] dq_oe_n_o,
  output logic                                 dm_o,
  output logic                                 dm_oe_n_o,
  output logic                                 dqs_p_o,
  output logic                                 dqs_n_o,
  output logic                                 dqs_oe_n_o
);
  import dmc_phy_pkg::*;

  logic [ptr_width_lp-1:0] wr_ptr;
  logic [ptr_width_lp-1:0] rd_ptr;
  logic                    wr_en_d;
  logic                    dqs_en;
  logic                    dqs_q;
  logic [lane_bits_lp-1:0] rd_even;
  logic [lane_bits_lp-1:0] rd_odd;

  // dqs runs one cycle past the enable so the last beat gets its edge.
  assign dqs_en = bus.wr_en | wr_en_d;

  always_ff @(posedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      wr_en_d    <= 1'b0;
      dqs_q      <= 1'b1;
      dqs_oe_n_o <= 1'b1;
    end else begin
      wr_en_d    <= bus.wr_en;
      dqs_q      <= dqs_en ? ~dqs_q : 1'b1;  // idles high, so the first rise centers beat 0.
      dqs_oe_n_o <= ~dqs_en;
    end
  end

  assign dqs_p_o = dqs_q;
  assign dqs_n_o = ~dqs_q;

  always_ff @(posedge dqs_n_i or posedge reset_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      rd_ptr <= '0;
    end else if (ck_phase_i && bus.rp_inc) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  for (genvar i = 0; i < lane_bits_lp; i++) begin : g_bit
    dmc_phy_tx_slice tx (
      .clk_2x_p (clk_2x_p),
      .reset_i  (reset_i),
      .wr_en_i  (bus.wr_en),
      .beats_i  ({bus.wr_data[lane_bits_lp+i], bus.wr_data[i]}),
      .pin_o    (dq_o[i]),
      .oe_n_o   (dq_oe_n_o[i])
    );

    dmc_phy_rx_slice rx (
      .clk_2x_p  (clk_2x_p),
      .dq_i      (dq_i[i]),
      .dqs_p_i   (dqs_p_i),
      .dqs_n_i   (dqs_n_i),
      .wr_ptr_i  (wr_ptr),
      .rd_ptr_i  (rd_ptr),
      .rd_even_o (rd_even[i]),
      .rd_odd_o  (rd_odd[i])
    );
  end

  dmc_phy_tx_slice dm_tx (
    .clk_2x_p (clk_2x_p),
    .reset_i  (reset_i),
    .wr_en_i  (bus.wr_en),
    .beats_i  (bus.wr_mask),
    .pin_o    (dm_o),
    .oe_n_o   (dm_oe_n_o)
  );

  assign bus.rd_data = {rd_odd, rd_even};

  // a read step with an empty fifo means the tap fired before the burst landed.
  a_rd_behind_wr: assert property (@(posedge clk_2x_p) disable iff (reset_i)
    (ck_phase_i && bus.rp_inc) |-> (rd_ptr != wr_ptr));

endmodule

/* dmc_phy_ctrl.sv */
`timescale 1ns/1ns

module dmc_phy_ctrl (
  input  logic                                      clk_2x_p,
  input  logic                                      reset_i,
  input  logic                                      dfi_cke_i,
  input  logic                                      dfi_cs_n_i,
  input  logic                                      dfi_ras_n_i,
  input  logic                                      dfi_cas_n_i,
  input  logic                                      dfi_we_n_i,
  input  logic [dmc_phy_pkg::bank_width_lp-1:0]     dfi_bank_i,
  input  logic [dmc_phy_pkg::addr_width_lp-1:0]     dfi_address_i,
  input  logic                                      dfi_wrdata_en_i,
  input  logic [dmc_phy_pkg::dfi_data_width_lp-1:0] dfi_wrdata_i,
  input  logic [2*dmc_phy_pkg::lane_count_lp-1:0]   dfi_wrdata_mask_i,
  input  logic                                      dfi_rddata_en_i,
  input  logic [dmc_phy_pkg::cal_width_lp-1:0]      dqs_sel_cal_i,
  output logic                                      ck_p_o,
  output logic                                      ck_n_o,
  output logic                                      ck_phase_o,
  output logic                                      cke_o,
  output logic                                      cs_n_o,
  output logic                                      ras_n_o,
  output logic                                      cas_n_o,
  output logic                                      we_n_o,
  output logic [dmc_phy_pkg::bank_width_lp-1:0]     ba_o,
  output logic [dmc_phy_pkg::addr_width_lp-1:0]     a_o,
  output logic                                      dqs_ie_n_o,
  output logic                                      valid_o,
  dmc_lane_if.ctrl                                  lanes [dmc_phy_pkg::lane_count_lp]
);
  import dmc_phy_pkg::*;

  logic                                   ck_phase;
  logic [4+bank_width_lp+addr_width_lp:0] cmd_s;
  logic [4+bank_width_lp+addr_width_lp:0] cmd_q;
  logic                                   wr_en_s;
  logic                                   wr_en_90;
  logic [dfi_data_width_lp-1:0]           wr_data_s;
  logic [dfi_data_width_lp-1:0]           wr_data_90;
  logic [2*lane_count_lp-1:0]             wr_mask_s;
  logic [2*lane_count_lp-1:0]             wr_mask_90;
  logic [cal_taps_lp-1:0]                 rd_tap;
  logic                                   rd_en_s;
  logic                                   rd_sel;
  logic                                   rp_q;

  // the 1x dram clock, high just before each sampling edge.
  always_ff @(posedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      ck_phase <= 1'b0;
    end else begin
      ck_phase <= ~ck_phase;
    end
  end

  assign ck_p_o     = ck_phase;
  assign ck_n_o     = ~ck_phase;
  assign ck_phase_o = ck_phase;

  always_ff @(posedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      cmd_s   <= {1'b0, 4'b1111, {bank_width_lp{1'b0}}, {addr_width_lp{1'b0}}};  // cke low.
      wr_en_s <= 1'b0;
      rd_en_s <= 1'b0;
      rp_q    <= 1'b0;
    end else if (ck_phase) begin
      cmd_s   <= {dfi_cke_i, dfi_cs_n_i, dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i,
                  dfi_bank_i, dfi_address_i};
      wr_en_s <= dfi_wrdata_en_i;
      rd_en_s <= dfi_rddata_en_i;
      rp_q    <= rd_sel;
    end
  end

  always_ff @(posedge clk_2x_p) begin
    if (ck_phase) begin
      wr_data_s <= dfi_wrdata_i;
      wr_mask_s <= dfi_wrdata_mask_i;
    end
  end

  // the pins take the sample one edge after it was taken.
  always_ff @(posedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      cmd_q <= {1'b0, 4'b1111, {bank_width_lp{1'b0}}, {addr_width_lp{1'b0}}};
    end else begin
      cmd_q <= cmd_s;
    end
  end

  assign {cke_o, cs_n_o, ras_n_o, cas_n_o, we_n_o, ba_o, a_o} = cmd_q;

  always_ff @(negedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      wr_en_90 <= 1'b0;
    end else begin
      wr_en_90 <= wr_en_s;
    end
  end

  always_ff @(negedge clk_2x_p) begin
    wr_data_90 <= wr_data_s;
    wr_mask_90 <= wr_mask_s;
  end

  // lane i carries dfi bytes i and i + lane_count_lp.
  for (genvar i = 0; i < lane_count_lp; i++) begin : g_lane
    assign lanes[i].wr_en   = wr_en_90;
    assign lanes[i].wr_data = {wr_data_90[(i+lane_count_lp)*lane_bits_lp +: lane_bits_lp],
                               wr_data_90[i*lane_bits_lp +: lane_bits_lp]};
    assign lanes[i].wr_mask = {wr_mask_90[i+lane_count_lp], wr_mask_90[i]};
    assign lanes[i].rp_inc  = rp_q;
  end

  assign rd_tap[0] = rd_en_s;

  // odd stages run on the falling edge and even stages on the rising edge.
  for (genvar k = 1; k < cal_taps_lp; k++) begin : g_tap
    logic q;
    if (k % 2 == 1) begin : g_fall
      always_ff @(negedge clk_2x_p or posedge reset_i) begin
        if (reset_i) begin
          q <= 1'b0;
        end else begin
          q <= rd_tap[k-1];
        end
      end
    end else begin : g_rise
      always_ff @(posedge clk_2x_p or posedge reset_i) begin
        if (reset_i) begin
          q <= 1'b0;
        end else begin
          q <= rd_tap[k-1];
        end
      end
    end
    assign rd_tap[k] = q;
  end

  assign rd_sel     = rd_tap[dqs_sel_cal_i];
  assign dqs_ie_n_o = ~rd_sel;
  assign valid_o    = rp_q;  // the gatherer registers this on the next sampling edge.

  // moving the tap mid-read would drop or repeat a pointer step.
  a_cal_stable: assert property (@(posedge clk_2x_p) disable iff (reset_i)
    (|rd_tap) |-> $stable(dqs_sel_cal_i));

endmodule

/* dmc_phy_rd_gather.sv */
`timescale 1ns/1ns

module dmc_phy_rd_gather (
  input  logic                                      clk_2x_p,
  input  logic                                      reset_i,
  input  logic                                      ck_phase_i,
  input  logic                                      valid_i,
  dmc_lane_if.gather                                lanes [dmc_phy_pkg::lane_count_lp],
  output logic [dmc_phy_pkg::dfi_data_width_lp-1:0] dfi_rddata_o,
  output logic                                      dfi_rddata_valid_o
);
  import dmc_phy_pkg::*;

  logic [dfi_data_width_lp-1:0] rd_word;

  // even bytes fill the low half of the word, odd bytes the high half.
  for (genvar i = 0; i < lane_count_lp; i++) begin : g_lane
    assign rd_word[i*lane_bits_lp +: lane_bits_lp] =
      lanes[i].rd_data[lane_bits_lp-1:0];
    assign rd_word[(i+lane_count_lp)*lane_bits_lp +: lane_bits_lp] =
      lanes[i].rd_data[2*lane_bits_lp-1:lane_bits_lp];
  end

  always_ff @(posedge clk_2x_p or posedge reset_i) begin
    if (reset_i) begin
      dfi_rddata_valid_o <= 1'b0;
    end else if (ck_phase_i) begin
      dfi_rddata_valid_o <= valid_i;
    end
  end

  // the last word is held until the next valid.
  always_ff @(posedge clk_2x_p) begin
    if (ck_phase_i && valid_i) begin
      dfi_rddata_o <= rd_word;
    end
  end

endmodule

/* dmc_phy_top.sv */
`timescale 1ns/1ns

module dmc_phy_top (
  input  logic                                      clk_2x_p,
  input  logic                                      reset_i,
  input  logic                                      dfi_cke_i,
  input  logic                                      dfi_cs_n_i,
  input  logic                                      dfi_ras_n_i,
  input  logic                                      dfi_cas_n_i,
  input  logic                                      dfi_we_n_i,
  input  logic [dmc_phy_pkg::bank_width_lp-1:0]     dfi_bank_i,
  input  logic [dmc_phy_pkg::addr_width_lp-1:0]     dfi_address_i,
  input  logic                                      dfi_wrdata_en_i,
  input  logic [dmc_phy_pkg::dfi_data_width_lp-1:0] dfi_wrdata_i,
  input  logic [2*dmc_phy_pkg::lane_count_lp-1:0]   dfi_wrdata_mask_i,
  input  logic                                      dfi_rddata_en_i,
  input  logic [dmc_phy_pkg::cal_width_lp-1:0]      dqs_sel_cal_i,
  input  logic [dmc_phy_pkg::dq_width_lp-1:0]       dq_i,
  input  logic [dmc_phy_pkg::lane_count_lp-1:0]     dqs_p_i,
  input  logic [dmc_phy_pkg::lane_count_lp-1:0]     dqs_n_i,
  output logic [dmc_phy_pkg::dfi_data_width_lp-1:0] dfi_rddata_o,
  output logic                                      dfi_rddata_valid_o,
  output logic                                      ck_p_o,
  output logic                                      ck_n_o,
  output logic                                      cke_o,
  output logic                                      cs_n_o,
  output logic                                      ras_n_o,
  output logic                                      cas_n_o,
  output logic                                      we_n_o,
  output logic [dmc_phy_pkg::bank_width_lp-1:0]     ba_o,
  output logic [dmc_phy_pkg::addr_width_lp-1:0]     a_o,
  output logic [dmc_phy_pkg::dq_width_lp-1:0]       dq_o,
  output logic [dmc_phy_pkg::dq_width_lp-1:0]       dq_oe_n_o,
  output logic [dmc_phy_pkg::lane_count_lp-1:0]     dm_o,
  output logic [dmc_phy_pkg::lane_count_lp-1:0]     dm_oe_n_o,
  output logic [dmc_phy_pkg::lane_count_lp-1:0]     dqs_p_o,
  output logic [dmc_phy_pkg::lane_count_lp-1:0]     dqs_n_o,
  output logic [dmc_phy_pkg::lane_count_lp-1:0]     dqs_oe_n_o,
  output logic                                      dqs_ie_n_o
);
  import dmc_phy_pkg::*;

  logic ck_phase;
  logic rd_valid;

  dmc_lane_if lane_bus [lane_count_lp] ();

  dmc_phy_ctrl ctrl0 (
    .clk_2x_p          (clk_2x_p),
    .reset_i           (reset_i),
    .dfi_cke_i         (dfi_cke_i),
    .dfi_cs_n_i        (dfi_cs_n_i),
    .dfi_ras_n_i       (dfi_ras_n_i),
    .dfi_cas_n_i       (dfi_cas_n_i),
    .dfi_we_n_i        (dfi_we_n_i),
    .dfi_bank_i        (dfi_bank_i),
    .dfi_address_i     (dfi_address_i),
    .dfi_wrdata_en_i   (dfi_wrdata_en_i),
    .dfi_wrdata_i      (dfi_wrdata_i),
    .dfi_wrdata_mask_i (dfi_wrdata_mask_i),
    .dfi_rddata_en_i   (dfi_rddata_en_i),
    .dqs_sel_cal_i     (dqs_sel_cal_i),
    .ck_p_o            (ck_p_o),
    .ck_n_o            (ck_n_o),
    .ck_phase_o        (ck_phase),
    .cke_o             (cke_o),
    .cs_n_o            (cs_n_o),
    .ras_n_o           (ras_n_o),
    .cas_n_o           (cas_n_o),
    .we_n_o            (we_n_o),
    .ba_o              (ba_o),
    .a_o               (a_o),
    .dqs_ie_n_o        (dqs_ie_n_o),
    .valid_o           (rd_valid),
    .lanes             (lane_bus)
  );

  for (genvar i = 0; i < lane_count_lp; i++) begin : lane
    dmc_phy_byte_lane byte_lane (
      .clk_2x_p   (clk_2x_p),
      .reset_i    (reset_i),
      .ck_phase_i (ck_phase),
      .bus        (lane_bus[i]),
      .dq_i       (dq_i[i*lane_bits_lp +: lane_bits_lp]),
      .dqs_p_i    (dqs_p_i[i]),
      .dqs_n_i    (dqs_n_i[i]),
      .dq_o       (dq_o[i*lane_bits_lp +: lane_bits_lp]),
      .dq_oe_n_o  (dq_oe_n_o[i*lane_bits_lp +: lane_bits_lp]),
      .dm_o       (dm_o[i]),
      .dm_oe_n_o  (dm_oe_n_o[i]),
      .dqs_p_o    (dqs_p_o[i]),
      .dqs_n_o    (dqs_n_o[i]),
      .dqs_oe_n_o (dqs_oe_n_o[i])
    );
  end

  dmc_phy_rd_gather gather0 (
    .clk_2x_p           (clk_2x_p),
    .reset_i            (reset_i),
    .ck_phase_i         (ck_phase),
    .valid_i            (rd_valid),
    .lanes              (lane_bus),
    .dfi_rddata_o       (dfi_rddata_o),
    .dfi_rddata_valid_o (dfi_rddata_valid_o)
  );

endmodule

/* dmc_phy_tb_clk.sv */
`timescale 1ns/1ns

module dmc_phy_tb_clk (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period.
  end

  // reset leaves on a falling edge, away from the sampling edges.
  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* dmc_phy_tb.sv */
`timescale 1ns/1ns

module dmc_phy_tb;
  import dmc_phy_pkg::*;

  logic                         clk_2x_p;
  logic                         reset_i;
  logic                         dfi_cke_i;
  logic                         dfi_cs_n_i;
  logic                         dfi_ras_n_i;
  logic                         dfi_cas_n_i;
  logic                         dfi_we_n_i;
  logic [bank_width_lp-1:0]     dfi_bank_i;
  logic [addr_width_lp-1:0]     dfi_address_i;
  logic                         dfi_wrdata_en_i;
  logic [dfi_data_width_lp-1:0] dfi_wrdata_i;
  logic [2*lane_count_lp-1:0]   dfi_wrdata_mask_i;
  logic                         dfi_rddata_en_i;
  logic [cal_width_lp-1:0]      dqs_sel_cal_i;
  logic [dq_width_lp-1:0]       dq_i;
  logic [lane_count_lp-1:0]     dqs_p_i;
  logic [lane_count_lp-1:0]     dqs_n_i;
  logic [dfi_data_width_lp-1:0] dfi_rddata_o;
  logic                         dfi_rddata_valid_o;
  logic                         ck_p_o;
  logic                         ck_n_o;
  logic                         cke_o;
  logic                         cs_n_o;
  logic                         ras_n_o;
  logic                         cas_n_o;
  logic                         we_n_o;
  logic [bank_width_lp-1:0]     ba_o;
  logic [addr_width_lp-1:0]     a_o;
  logic [dq_width_lp-1:0]       dq_o;
  logic [dq_width_lp-1:0]       dq_oe_n_o;
  logic [lane_count_lp-1:0]     dm_o;
  logic [lane_count_lp-1:0]     dm_oe_n_o;
  logic [lane_count_lp-1:0]     dqs_p_o;
  logic [lane_count_lp-1:0]     dqs_n_o;
  logic [lane_count_lp-1:0]     dqs_oe_n_o;
  logic                         dqs_ie_n_o;

  int                           err_cnt = 0;
  int                           pass_cnt = 0;
  int                           fail_cnt = 0;
  int                           cur_tap = 2;
  int                           rd_issued = 0;
  int                           rd_seen = 0;
  time                          last_latency = 0;
  time                          issue_t = 0;
  time                          ie_fall_t = 0;
  logic [dfi_data_width_lp-1:0] rd_exp_q [$];
  time                          rd_time_q [$];
  logic [dq_width_lp+lane_count_lp-1:0] wr_exp_q [$];  // {dm, dq} per beat.
  logic [lane_count_lp-1:0]     dqs_prev;
  logic [lane_count_lp-1:0]     dqs_oe_prev;
  logic                         ck_prev;
  logic                         rst_prev;

  dmc_phy_tb_clk clk_gen (
    .clk_o   (clk_2x_p),
    .reset_o (reset_i)
  );

  dmc_phy_top dut0 (
    .clk_2x_p           (clk_2x_p),
    .reset_i            (reset_i),
    .dfi_cke_i          (dfi_cke_i),
    .dfi_cs_n_i         (dfi_cs_n_i),
    .dfi_ras_n_i        (dfi_ras_n_i),
    .dfi_cas_n_i        (dfi_cas_n_i),
    .dfi_we_n_i         (dfi_we_n_i),
    .dfi_bank_i         (dfi_bank_i),
    .dfi_address_i      (dfi_address_i),
    .dfi_wrdata_en_i    (dfi_wrdata_en_i),
    .dfi_wrdata_i       (dfi_wrdata_i),
    .dfi_wrdata_mask_i  (dfi_wrdata_mask_i),
    .dfi_rddata_en_i    (dfi_rddata_en_i),
    .dqs_sel_cal_i      (dqs_sel_cal_i),
    .dq_i               (dq_i),
    .dqs_p_i            (dqs_p_i),
    .dqs_n_i            (dqs_n_i),
    .dfi_rddata_o       (dfi_rddata_o),
    .dfi_rddata_valid_o (dfi_rddata_valid_o),
    .ck_p_o             (ck_p_o),
    .ck_n_o             (ck_n_o),
    .cke_o              (cke_o),
    .cs_n_o             (cs_n_o),
    .ras_n_o            (ras_n_o),
    .cas_n_o            (cas_n_o),
    .we_n_o             (we_n_o),
    .ba_o               (ba_o),
    .a_o                (a_o),
    .dq_o               (dq_o),
    .dq_oe_n_o          (dq_oe_n_o),
    .dm_o               (dm_o),
    .dm_oe_n_o          (dm_oe_n_o),
    .dqs_p_o            (dqs_p_o),
    .dqs_n_o            (dqs_n_o),
    .dqs_oe_n_o         (dqs_oe_n_o),
    .dqs_ie_n_o         (dqs_ie_n_o)
  );

  // byte l of the dfi word is the even beat of lane l, byte l+2 its odd beat.
  function automatic logic [dfi_data_width_lp-1:0] ref_read_word(
    input logic [dq_width_lp-1:0] ev,
    input logic [dq_width_lp-1:0] od
  );
    logic [dfi_data_width_lp-1:0] w;
    for (int l = 0; l < lane_count_lp; l++) begin
      w[l*lane_bits_lp +: lane_bits_lp] = ev[l*lane_bits_lp +: lane_bits_lp];
      w[(l+lane_count_lp)*lane_bits_lp +: lane_bits_lp] = od[l*lane_bits_lp +: lane_bits_lp];
    end
    return w;
  endfunction

  function automatic logic [dq_width_lp+lane_count_lp-1:0] ref_write_beat(
    input logic [dfi_data_width_lp-1:0] d,
    input logic [2*lane_count_lp-1:0]   m,
    input bit                           odd
  );
    logic [dq_width_lp+lane_count_lp-1:0] b;
    for (int l = 0; l < lane_count_lp; l++) begin
      b[l*lane_bits_lp +: lane_bits_lp] = odd ? d[(l+lane_count_lp)*lane_bits_lp +: lane_bits_lp]
                                              : d[l*lane_bits_lp +: lane_bits_lp];
      b[dq_width_lp+l] = odd ? m[l+lane_count_lp] : m[l];
    end
    return b;
  endfunction

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display("test failed");
    $finish;
  endtask

  // falling edge just before a dfi sampling edge.
  task automatic wait_sample_point();
    int tries;
    tries = 0;
    do begin
      @(negedge clk_2x_p);
      tries++;
    end while (!ck_p_o && tries < 4);
    if (!ck_p_o) abort_run("a dfi sampling edge");
  endtask

  // dram side of a read: even beat on the dqs rise, odd beat on the fall.
  task automatic send_burst(input logic [dq_width_lp-1:0] ev, input logic [dq_width_lp-1:0] od,
                            input int dly);
    #dly;
    dq_i = ev;
    #1;
    dqs_p_i = '1;
    dqs_n_i = '0;
    #1;
    dq_i = od;
    #1;
    dqs_p_i = '0;
    dqs_n_i = '1;
  endtask

  task automatic issue_read();
    logic [dq_width_lp-1:0] ev;
    logic [dq_width_lp-1:0] od;
    ev = $urandom;
    od = $urandom;
    wait_sample_point();
    rd_exp_q.push_back(ref_read_word(ev, od));
    rd_time_q.push_back($time);
    issue_t = $time;
    rd_issued++;
    dfi_rddata_en_i = 1'b1;
    fork
      send_burst(ev, od, 2 + 2 * cur_tap);  // the burst lands later for later taps.
    join_none
    @(negedge clk_2x_p);
    dfi_rddata_en_i = 1'b0;
  endtask

  task automatic issue_write(input logic [dfi_data_width_lp-1:0] d,
                             input logic [2*lane_count_lp-1:0] m);
    wait_sample_point();
    wr_exp_q.push_back(ref_write_beat(d, m, 1'b0));
    wr_exp_q.push_back(ref_write_beat(d, m, 1'b1));
    dfi_wrdata_en_i   = 1'b1;
    dfi_wrdata_i      = d;
    dfi_wrdata_mask_i = m;
    @(negedge clk_2x_p);
    dfi_wrdata_en_i = 1'b0;
  endtask

  task automatic wait_reads_done();
    int tries;
    tries = 0;
    while (rd_exp_q.size() != 0 && tries < 60) begin
      @(negedge clk_2x_p);
      tries++;
    end
    if (rd_exp_q.size() != 0) abort_run("read valid");
    repeat (4) @(negedge clk_2x_p);
  endtask

  task automatic wait_writes_done();
    int tries;
    tries = 0;
    while (wr_exp_q.size() != 0 && tries < 60) begin
      @(negedge clk_2x_p);
      tries++;
    end
    if (wr_exp_q.size() != 0) abort_run("write beats on dq");
    repeat (6) @(negedge clk_2x_p);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: FAILED with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  always @(negedge clk_2x_p) begin : check_read
    logic [dfi_data_width_lp-1:0] exp;
    time                          t0;
    if (!reset_i && dfi_rddata_valid_o && !ck_p_o) begin
      rd_seen++;
      if (rd_exp_q.size() == 0) begin
        $display("ERR %0t: read valid with no read outstanding", $time);
        err_cnt++;
      end else begin
        exp = rd_exp_q.pop_front();
        t0 = rd_time_q.pop_front();
        last_latency = $time - t0;
        if (dfi_rddata_o !== exp) begin
          $display("ERR %0t: read word %h, expected %h", $time, dfi_rddata_o, exp);
          err_cnt++;
        end
      end
    end
  end

  // the read enable window opens on either clock edge, so its start is timed directly.
  always @(negedge dqs_ie_n_o) begin
    ie_fall_t = $time;
  end

  // the tx pins change on falling edges, so they are looked at on rising ones.
  always @(posedge clk_2x_p) begin : check_write
    logic [dq_width_lp+lane_count_lp-1:0] exp;
    if (!reset_i && (dm_oe_n_o != '1 || dq_oe_n_o != '1)) begin
      if (dm_oe_n_o != '0 || dq_oe_n_o != '0) begin
        $display("ERR %0t: partial output enable dq %h dm %b", $time, dq_oe_n_o, dm_oe_n_o);
        err_cnt++;
      end else if (wr_exp_q.size() == 0) begin
        $display("ERR %0t: write beat %h with no write pending", $time, dq_o);
        err_cnt++;
      end else begin
        exp = wr_exp_q.pop_front();
        if ({dm_o, dq_o} !== exp) begin
          $display("ERR %0t: write beat %h, expected %h", $time, {dm_o, dq_o}, exp);
          err_cnt++;
        end
      end
    end
  end

  always @(negedge clk_2x_p) begin : check_dqs
    if (!reset_i) begin
      for (int l = 0; l < lane_count_lp; l++) begin
        if (dqs_p_o[l] != dqs_prev[l] && dqs_oe_prev[l] && dqs_oe_n_o[l]) begin
          $display("ERR %0t: dqs of lane %0d toggled while not driven", $time, l);
          err_cnt++;
        end
        if (dqs_n_o[l] !== ~dqs_p_o[l]) begin
          $display("ERR %0t: dqs_n of lane %0d is not the complement", $time, l);
          err_cnt++;
        end
      end
    end
    dqs_prev    = dqs_p_o;
    dqs_oe_prev = dqs_oe_n_o;
  end

  // the dram clock pair flips on every rising edge once reset is gone.
  always @(negedge clk_2x_p) begin : check_ck
    if (!reset_i && !rst_prev) begin
      if (ck_p_o === ck_prev || ck_n_o !== ~ck_p_o) begin
        $display("ERR %0t: dram clock ck_p %b ck_n %b, previous ck_p %b", $time, ck_p_o,
                 ck_n_o, ck_prev);
        err_cnt++;
      end
    end
    ck_prev  = ck_p_o;
    rst_prev = reset_i;
  end

  initial begin
    int                       errs;
    int                       tries;
    int                       lat_prev;
    int                       ie_prev;
    logic [31:0]              r;
    logic [4:0]               cmd_exp;
    logic [bank_width_lp-1:0] ba_exp;
    logic [addr_width_lp-1:0] a_exp;
    bit                       have_cmd;

    void'($urandom(32'hf5a4));
    dfi_cke_i         = 1'b0;
    dfi_cs_n_i        = 1'b1;
    dfi_ras_n_i       = 1'b1;
    dfi_cas_n_i       = 1'b1;
    dfi_we_n_i        = 1'b1;
    dfi_bank_i        = '0;
    dfi_address_i     = '0;
    dfi_wrdata_en_i   = 1'b0;
    dfi_wrdata_i      = '0;
    dfi_wrdata_mask_i = '0;
    dfi_rddata_en_i   = 1'b0;
    dqs_sel_cal_i     = cur_tap;
    dq_i              = '0;
    dqs_p_i           = '0;
    dqs_n_i           = '0;
    #1;
    dqs_n_i = '1;  // idle level, reached while reset still holds the write pointer.

    tries = 0;
    while (reset_i !== 1'b0 && tries < 40) begin
      @(negedge clk_2x_p);
      tries++;
    end
    if (reset_i !== 1'b0) abort_run("reset release");

    errs = err_cnt;
    @(negedge clk_2x_p);
    if (dq_oe_n_o !== '1 || dm_oe_n_o !== '1 || dqs_oe_n_o !== '1 || dqs_ie_n_o !== 1'b1) begin
      $display("ERR %0t: output enables not idle after reset", $time);
      err_cnt++;
    end
    if ({cke_o, cs_n_o, ras_n_o, cas_n_o, we_n_o} !== 5'b01111 || dfi_rddata_valid_o !== 1'b0) begin
      $display("ERR %0t: command pins or read valid wrong after reset", $time);
      err_cnt++;
    end
    finish_test("reset state", errs);

    errs = err_cnt;
    have_cmd = 1'b0;
    for (int n = 0; n <= 12; n++) begin
      wait_sample_point();
      if (have_cmd) begin
        if ({cke_o, cs_n_o, ras_n_o, cas_n_o, we_n_o} !== cmd_exp || ba_o !== ba_exp ||
            a_o !== a_exp) begin
          $display("ERR %0t: command pins %b %h %h, expected %b %h %h", $time,
                   {cke_o, cs_n_o, ras_n_o, cas_n_o, we_n_o}, ba_o, a_o, cmd_exp, ba_exp, a_exp);
          err_cnt++;
        end
      end
      r = $urandom;
      cmd_exp = r[4:0];
      ba_exp  = r[7:5];
      a_exp   = r[31:16];
      {dfi_cke_i, dfi_cs_n_i, dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i} = cmd_exp;
      dfi_bank_i    = ba_exp;
      dfi_address_i = a_exp;
      have_cmd = 1'b1;
    end
    dfi_cs_n_i = 1'b1;
    finish_test("command pass-through", errs);

    errs = err_cnt;
    for (int n = 0; n < 10; n++) begin
      r = $urandom;
      issue_write($urandom, r[3:0]);
      if (r[4]) wait_sample_point();  // otherwise the next word follows back to back.
    end
    wait_writes_done();
    finish_test("write serialization", errs);

    errs = err_cnt;
    rd_issued = 0;
    rd_seen = 0;
    for (int n = 0; n < 8; n++) begin
      r = $urandom;
      issue_read();
      if (r[0]) wait_sample_point();
    end
    wait_reads_done();
    if (rd_seen != rd_issued) begin
      $display("ERR %0t: %0d read valids for %0d reads", $time, rd_seen, rd_issued);
      err_cnt++;
    end
    finish_test("read gathering", errs);

    errs = err_cnt;
    lat_prev = -1;
    ie_prev = -1;
    for (int tap = 0; tap < cal_taps_lp; tap++) begin
      @(negedge clk_2x_p);
      cur_tap = tap;
      dqs_sel_cal_i = tap;
      issue_read();
      wait_reads_done();
      // a later tap never shortens the latency, and adds at most one 1x cycle.
      if (lat_prev >= 0 && (last_latency < lat_prev || last_latency > lat_prev + 8)) begin
        $display("ERR %0t: tap %0d latency %0t after %0d", $time, tap, last_latency, lat_prev);
        err_cnt++;
      end
      lat_prev = last_latency;
      // each tap opens the read enable half a 2x cycle later.
      if (ie_prev >= 0 && ie_fall_t - issue_t != ie_prev + 2) begin
        $display("ERR %0t: tap %0d read enable after %0t, expected %0d", $time, tap,
                 ie_fall_t - issue_t, ie_prev + 2);
        err_cnt++;
      end
      ie_prev = ie_fall_t - issue_t;
    end
    finish_test("calibration sweep", errs);

    errs = err_cnt;
    @(negedge clk_2x_p);
    cur_tap = 2;
    dqs_sel_cal_i = 2;
    rd_issued = 0;
    rd_seen = 0;
    for (int n = 0; n < fifo_depth_lp; n++) begin
      issue_read();
    end
    wait_reads_done();
    if (rd_seen != fifo_depth_lp) begin
      $display("ERR %0t: %0d of %0d back to back reads returned", $time, rd_seen, fifo_depth_lp);
      err_cnt++;
    end
    finish_test("fifo depth", errs);

    $display("tests passed %0d, tests failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* dmc_phy_top.f */
dmc_phy_pkg.sv
dmc_lane_if.sv
dmc_phy_tx_slice.sv
dmc_phy_rx_slice.sv
dmc_phy_byte_lane.sv
dmc_phy_ctrl.sv
dmc_phy_rd_gather.sv
dmc_phy_top.sv
dmc_phy_tb_clk.sv
dmc_phy_tb.sv

/* Bender.yml */
package:
  name: dmc_phy

sources:
  - dmc_phy_pkg.sv
  - dmc_lane_if.sv
  - dmc_phy_tx_slice.sv
  - dmc_phy_rx_slice.sv
  - dmc_phy_byte_lane.sv
  - dmc_phy_ctrl.sv
  - dmc_phy_rd_gather.sv
  - dmc_phy_top.sv
  - target: test
    files:
      - dmc_phy_tb_clk.sv
      - dmc_phy_tb.sv
